// File: hw/iir_pkg.sv
// Biquad system package with widths, register map, Q format and bus structs
package iir_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;
  localparam int WAVE_W     = 16;
  localparam int COEF_W     = 32;
  localparam int Q_BITS     = 14;                    // fraction bits of coefficients
  localparam int PROD_W     = COEF_W + WAVE_W;       // one coefficient times one sample
  localparam int ACC_W      = PROD_W + 3;            // headroom for five terms
  localparam int DIV_CNT_W  = $clog2(APB_DATA_W);    // divider step counter

  typedef logic        [APB_DATA_W-1:0] apb_word_t;
  typedef logic        [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic signed [WAVE_W-1:0]     wave_t;
  typedef logic signed [COEF_W-1:0]     coef_t;

  localparam apb_word_t SYS_CLK_HZ = 32'd250_000_000;

  localparam wave_t WAVE_MAX = 16'sh7fff;
  localparam wave_t WAVE_MIN = 16'sh8000;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam apb_addr_t REG_FS     = 8'h00;          // sampling frequency in Hz
  localparam apb_addr_t REG_BYPASS = 8'h04;          // bit 0 only
  localparam apb_addr_t REG_B0     = 8'h08;
  localparam apb_addr_t REG_B1     = 8'h0c;
  localparam apb_addr_t REG_B2     = 8'h10;
  localparam apb_addr_t REG_A1     = 8'h14;
  localparam apb_addr_t REG_A2     = 8'h18;
  localparam apb_addr_t REG_PERIOD = 8'h1c;          // read only

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    apb_word_t prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic  bypass;
    coef_t b0;
    coef_t b1;
    coef_t b2;
    coef_t a1;
    coef_t a2;
  } iir_cfg_t;

  typedef struct packed {
    logic      start;
    apb_word_t dividend;
    apb_word_t divisor;
  } div_req_t;

  typedef struct packed {
    logic      done;
    logic      busy;
    apb_word_t quotient;
  } div_rsp_t;

endpackage

// File: hw/iir_apb_regs.sv
// APB3 slave holding the biquad configuration registers and their readback
`timescale 1ns/1ps
`default_nettype none

module iir_apb_regs import iir_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,

  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,

  input  apb_word_t period,       // derived sample period, read only
  output iir_cfg_t  cfg,
  output apb_word_t fs,
  output logic      fs_written
);

  iir_cfg_t  cfg_q;
  apb_word_t fs_q;
  logic      fs_written_q;

  logic      wr_en;
  logic      rd_en;
  apb_word_t rd_data;

  // write commits in the access phase, no wait states
  assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign rd_en = apb_req.psel && !apb_req.pwrite;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q        <= '0;
      fs_q         <= '0;
      fs_written_q <= 1'b0;
    end else begin
      fs_written_q <= wr_en && (apb_req.paddr == REG_FS);   // lands with new fs
      if (wr_en) begin
        case (apb_req.paddr)
          REG_FS:     fs_q         <= apb_req.pwdata;
          REG_BYPASS: cfg_q.bypass <= apb_req.pwdata[0];
          REG_B0:     cfg_q.b0     <= coef_t'(apb_req.pwdata);
          REG_B1:     cfg_q.b1     <= coef_t'(apb_req.pwdata);
          REG_B2:     cfg_q.b2     <= coef_t'(apb_req.pwdata);
          REG_A1:     cfg_q.a1     <= coef_t'(apb_req.pwdata);
          REG_A2:     cfg_q.a2     <= coef_t'(apb_req.pwdata);
          default:    ;                                      // unmapped, dropped
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (apb_req.paddr)
      REG_FS:     rd_data = fs_q;
      REG_BYPASS: rd_data = {{(APB_DATA_W-1){1'b0}}, cfg_q.bypass};
      REG_B0:     rd_data = apb_word_t'(cfg_q.b0);
      REG_B1:     rd_data = apb_word_t'(cfg_q.b1);
      REG_B2:     rd_data = apb_word_t'(cfg_q.b2);
      REG_A1:     rd_data = apb_word_t'(cfg_q.a1);
      REG_A2:     rd_data = apb_word_t'(cfg_q.a2);
      REG_PERIOD: rd_data = period;
      default:    rd_data = '0;                              // holes read zero
    endcase
  end

  assign apb_rsp.pready = 1'b1;
  assign apb_rsp.prdata = rd_en ? rd_data : '0;

  assign cfg        = cfg_q;
  assign fs         = fs_q;
  assign fs_written = fs_written_q;

  // master must hold psel through the access phase
  penable_needs_psel: assert property (
    @(posedge clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel
  );

endmodule

`default_nettype wire

// File: hw/long_divider.sv
// Restoring shift-subtract divider, one quotient bit per clock over 32 cycles
`timescale 1ns/1ps
`default_nettype none

module long_divider import iir_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,

  input  div_req_t req,
  output div_rsp_t rsp
);

  logic                 busy_q;
  logic [DIV_CNT_W-1:0] cnt_q;        // steps already registered
  apb_word_t            rem_q;        // partial remainder
  apb_word_t            quo_q;        // dividend bits out, quotient bits in
  apb_word_t            dsr_q;

  logic [APB_DATA_W:0]  trial;
  apb_word_t            rem_n;
  apb_word_t            quo_n;
  logic                 done;

  // one restoring step, the last one goes straight to the output
  always_comb begin
    trial = {rem_q, quo_q[APB_DATA_W-1]} - {1'b0, dsr_q};
    if (!trial[APB_DATA_W]) begin
      rem_n = trial[APB_DATA_W-1:0];
      quo_n = {quo_q[APB_DATA_W-2:0], 1'b1};
    end else begin
      rem_n = {rem_q[APB_DATA_W-2:0], quo_q[APB_DATA_W-1]};
      quo_n = {quo_q[APB_DATA_W-2:0], 1'b0};
    end
  end

  assign done = busy_q && (cnt_q == '1);   // 32nd step, 32 cycles after start

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (req.start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.start) begin
      rem_q <= '0;
      quo_q <= req.dividend;
      dsr_q <= req.divisor;
    end else if (busy_q) begin
      rem_q <= rem_n;
      quo_q <= quo_n;
    end
  end

  assign rsp.done     = done;
  assign rsp.busy     = busy_q;
  assign rsp.quotient = (dsr_q == '0) ? '0 : quo_n;   // divide by zero gives 0

  // client may only launch into an idle divider
  start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    req.start |-> !rsp.busy
  );

endmodule

`default_nettype wire

// File: hw/sample_enable.sv
// Sample strobe generator, divides clock rate by fs and strobes once per period
`timescale 1ns/1ps
`default_nettype none

module sample_enable import iir_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,

  input  apb_word_t fs,
  input  wire       fs_written,
  output apb_word_t period,
  output logic      sample_en
);

  div_req_t  div_req;
  div_rsp_t  div_rsp;

  logic      pending_q;      // fs changed, division still owed
  logic      start_q;
  logic      run_q;          // strobing allowed
  apb_word_t period_q;
  apb_word_t cnt_q;

  logic      launch;
  logic      period_ok;

  assign launch    = pending_q && !div_rsp.busy && !start_q;
  assign period_ok = div_rsp.quotient >= 2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      start_q   <= 1'b0;
      run_q     <= 1'b0;
      period_q  <= '0;
      cnt_q     <= '0;
    end else begin
      start_q <= launch;

      if (fs_written) begin
        pending_q <= 1'b1;
      end else if (launch) begin
        pending_q <= 1'b0;
      end

      // stale result while another fs waits, keep quiet
      if (fs_written) begin
        run_q <= 1'b0;
      end else if (div_rsp.done) begin
        run_q <= period_ok && !pending_q;
      end

      if (div_rsp.done) begin
        period_q <= div_rsp.quotient;
        cnt_q    <= div_rsp.quotient - 1'b1;
      end else if (run_q) begin
        cnt_q <= (cnt_q == '0) ? period_q - 1'b1 : cnt_q - 1'b1;   // reload
      end
    end
  end

  assign div_req.start    = start_q;
  assign div_req.dividend = SYS_CLK_HZ;
  assign div_req.divisor  = fs;

  long_divider long_divider_i0 (
    .clk   ( clk     ), // input
    .rst_n ( rst_n   ), // input
    .req   ( div_req ), // input
    .rsp   ( div_rsp )  // output
  );

  assign period    = period_q;
  assign sample_en = run_q && (cnt_q == '0);

  // strobes are at least two cycles apart
  no_back_to_back: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_en |=> !sample_en
  );

endmodule

`default_nettype wire

// File: hw/biquad_core.sv
// Direct-form-I biquad with saturating output, history registers and bypass
`timescale 1ns/1ps
`default_nettype none

module biquad_core import iir_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,

  input  iir_cfg_t cfg,
  input  wire      sample_en,
  input  wave_t    x,
  output wave_t    y,
  output logic     y_valid
);

  wave_t                    x1_q;    // x[n-1]
  wave_t                    x2_q;    // x[n-2]
  wave_t                    y1_q;    // y[n-1]
  wave_t                    y2_q;    // y[n-2]
  wave_t                    y_q;
  logic                     y_valid_q;

  logic signed [PROD_W-1:0] p_b0;
  logic signed [PROD_W-1:0] p_b1;
  logic signed [PROD_W-1:0] p_b2;
  logic signed [PROD_W-1:0] p_a1;
  logic signed [PROD_W-1:0] p_a2;
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  acc_sh;
  wave_t                    y_sat;

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    p_b0 = cfg.b0 * x;
    p_b1 = cfg.b1 * x1_q;
    p_b2 = cfg.b2 * x2_q;
    p_a1 = cfg.a1 * y1_q;
    p_a2 = cfg.a2 * y2_q;

    acc    = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;   // full precision
    acc_sh = acc >>> Q_BITS;                     // floor to sample scale

    if (acc_sh > WAVE_MAX) begin
      y_sat = WAVE_MAX;
    end else if (acc_sh < WAVE_MIN) begin
      y_sat = WAVE_MIN;
    end else begin
      y_sat = wave_t'(acc_sh[WAVE_W-1:0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // history and output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x1_q      <= '0;
      x2_q      <= '0;
      y1_q      <= '0;
      y2_q      <= '0;
      y_q       <= '0;
      y_valid_q <= 1'b0;
    end else begin
      y_valid_q <= sample_en;
      if (sample_en) begin
        if (cfg.bypass) begin
          y_q  <= x;                 // straight through
          x1_q <= '0;                // restart from rest on exit
          x2_q <= '0;
          y1_q <= '0;
          y2_q <= '0;
        end else begin
          y_q  <= y_sat;
          x1_q <= x;
          x2_q <= x1_q;
          y1_q <= y_sat;
          y2_q <= y1_q;
        end
      end
    end
  end

  assign y       = y_q;
  assign y_valid = y_valid_q;

  // strobed input sample must be known
  x_known_on_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_en |-> !$isunknown(x)
  );

endmodule

`default_nettype wire

// File: hw/iir_biquad_system.sv
// Biquad system top joining the APB registers, sample strobe and filter
`timescale 1ns/1ps
`default_nettype none

module iir_biquad_system import iir_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,

  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,

  input  wave_t    x,
  output wave_t    y,
  output logic     y_valid
);

  iir_cfg_t  cfg;
  apb_word_t fs;
  logic      fs_written;
  apb_word_t period;
  logic      sample_en;

  iir_apb_regs iir_apb_regs_i0 (
    .clk        ( clk        ), // input
    .rst_n      ( rst_n      ), // input
    .apb_req    ( apb_req    ), // input
    .apb_rsp    ( apb_rsp    ), // output
    .period     ( period     ), // input
    .cfg        ( cfg        ), // output
    .fs         ( fs         ), // output
    .fs_written ( fs_written )  // output
  );

  sample_enable sample_enable_i0 (
    .clk        ( clk        ), // input
    .rst_n      ( rst_n      ), // input
    .fs         ( fs         ), // input
    .fs_written ( fs_written ), // input
    .period     ( period     ), // output
    .sample_en  ( sample_en  )  // output
  );

  biquad_core biquad_core_i0 (
    .clk        ( clk        ), // input
    .rst_n      ( rst_n      ), // input
    .cfg        ( cfg        ), // input
    .sample_en  ( sample_en  ), // input
    .x          ( x          ), // input
    .y          ( y          ), // output
    .y_valid    ( y_valid    )  // output
  );

endmodule

`default_nettype wire

// File: sim/iir_tb.sv
// Directed testbench for the APB biquad system with a reference filter model
`timescale 1ns/1ps

module iir_tb import iir_pkg::*; ();

  logic      clk;
  logic      rst_n;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  wave_t     x;
  wave_t     y;
  logic      y_valid;

  apb_word_t lcg_state;
  int        word_errors;
  int        wave_errors;
  int        flag_errors;
  int        other_errors;
  longint    m_coef [5];     // b0 b1 b2 a1 a2
  longint    m_hist [4];     // x1 x2 y1 y2

  iir_biquad_system u_iir_biquad_system (
    .clk     ( clk     ), // input
    .rst_n   ( rst_n   ), // input
    .apb_req ( apb_req ), // input
    .apb_rsp ( apb_rsp ), // output
    .x       ( x       ), // input
    .y       ( y       ), // output
    .y_valid ( y_valid )  // output
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic apb_word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_word(input string name, input apb_word_t got, input apb_word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("Error at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_wave(input string name, input wave_t got, input wave_t exp);
    if (got !== exp) begin
      wave_errors++;
      $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("Error at %0t: %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;      // setup phase
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;      // access phase
    @(negedge clk);
    check_flag("pready", apb_rsp.pready, 1'b1);
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_word_t data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;        // mid access cycle
    check_flag("pready", apb_rsp.pready, 1'b1);
    @(posedge clk);
    apb_req <= '0;
  endtask

  // cycles until y_valid within a bound of 100
  task automatic wait_valid(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 100) begin
      @(negedge clk);
      cycles++;
      seen = y_valid;
    end
    if (!seen) begin
      other_errors++;
      $display("Timeout at %0t: y_valid did not arrive within 100 cycles", $time);
    end
  endtask

  // x moves in the cycle after the last y_valid
  task automatic sample_step(input wave_t xin, output wave_t yout);
    int cycles;
    @(posedge clk);
    x <= xin;
    wait_valid(cycles);
    yout = y;
  endtask

  task automatic poll_period(input apb_word_t exp);
    apb_word_t rd;
    int        tries;
    tries = 0;
    rd    = ~exp;
    while (rd !== exp && tries < 40) begin
      apb_read(REG_PERIOD, rd);
      tries++;
    end
    check_word("REG_PERIOD", rd, exp);
  endtask

  task automatic model_step(input wave_t xin, output wave_t yexp);
    longint acc;
    acc = m_coef[0] * xin + m_coef[1] * m_hist[0] + m_coef[2] * m_hist[1]
        - m_coef[3] * m_hist[2] - m_coef[4] * m_hist[3];
    acc = acc >>> Q_BITS;         // floor
    if (acc > 64'sd32767) begin
      yexp = 16'sh7fff;
    end else if (acc < -64'sd32768) begin
      yexp = 16'sh8000;
    end else begin
      yexp = wave_t'(acc);
    end
    m_hist[1] = m_hist[0];
    m_hist[0] = xin;
    m_hist[3] = m_hist[2];
    m_hist[2] = yexp;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic register_access();
    apb_addr_t addr [7];
    apb_word_t val [7];
    apb_word_t rd;
    addr = '{REG_FS, REG_BYPASS, REG_B0, REG_B1, REG_B2, REG_A1, REG_A2};
    for (int i = 0; i < 7; i++) begin
      val[i] = lcg_next();
      apb_write(addr[i], val[i]);
    end
    for (int i = 0; i < 7; i++) begin
      apb_read(addr[i], rd);
      check_word($sformatf("prdata[0x%02h]", addr[i]), rd,
                 (addr[i] == REG_BYPASS) ? (val[i] & 32'd1) : val[i]);
    end
    apb_read(8'h20, rd);
    check_word("prdata[0x20]", rd, '0);   // hole reads zero
  endtask

  task automatic period_update();
    int gap;
    apb_write(REG_FS, 32'd25_000_000);
    poll_period(SYS_CLK_HZ / 32'd25_000_000);
    wait_valid(gap);
    wait_valid(gap);
    check_word("y_valid spacing", apb_word_t'(gap), SYS_CLK_HZ / 32'd25_000_000);
    apb_write(REG_FS, 32'd12_500_000);
    poll_period(SYS_CLK_HZ / 32'd12_500_000);
  endtask

  task automatic bypass_path();
    wave_t xin;
    wave_t yout;
    int    gap;
    apb_write(REG_BYPASS, 32'd1);
    wait_valid(gap);
    for (int i = 0; i < 8; i++) begin
      xin = wave_t'(lcg_next() >> 16);
      sample_step(xin, yout);
      check_wave("y (bypass)", yout, xin);
    end
    sample_step('0, yout);        // park x at zero so history stays at rest
  endtask

  task automatic filter_response();
    apb_word_t cw [5];
    wave_t     xin;
    wave_t     yout;
    wave_t     yexp;
    int        gap;
    cw = '{32'd8192, 32'd4096, 32'd2048, 32'hffff_e000, 32'd4096};   // Q14
    for (int i = 0; i < 5; i++) begin
      apb_write(REG_B0 + apb_addr_t'(4 * i), cw[i]);
      m_coef[i] = longint'(coef_t'(cw[i]));
    end
    m_hist = '{default: 0};
    apb_write(REG_BYPASS, 32'd0);
    wait_valid(gap);
    for (int i = 0; i < 16; i++) begin
      xin = wave_t'(lcg_next() >> 16);
      sample_step(xin, yout);
      model_step(xin, yexp);
      check_wave("y (filter)", yout, yexp);
    end
  endtask

  task automatic saturation_limits();
    wave_t yout;
    int    gap;
    apb_write(REG_B0, 32'd32604);          // 1.99
    for (int i = 1; i < 5; i++) begin
      apb_write(REG_B0 + apb_addr_t'(4 * i), 32'd0);
    end
    wait_valid(gap);
    sample_step(16'sh7fff, yout);
    check_wave("y (positive limit)", yout, 16'sh7fff);
    sample_step(16'sh8000, yout);
    check_wave("y (negative limit)", yout, 16'sh8000);
  endtask

  task automatic zero_frequency();
    apb_word_t fs_val [2];
    apb_word_t per_val [2];
    int        strobes;
    fs_val  = '{SYS_CLK_HZ, 32'd0};
    per_val = '{32'd1, 32'd0};             // both too short to strobe
    for (int k = 0; k < 2; k++) begin
      strobes = 0;
      apb_write(REG_FS, fs_val[k]);
      poll_period(per_val[k]);
      repeat (200) begin
        @(negedge clk);
        if (y_valid) begin
          strobes++;
        end
      end
      if (strobes != 0) begin
        other_errors++;
        $display("Failure at %0t: %0d y_valid pulses seen with fs set to %0d", $time,
                 strobes, fs_val[k]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    apb_req      = '0;
    x            = '0;
    lcg_state    = 32'd26;
    word_errors  = 0;
    wave_errors  = 0;
    flag_errors  = 0;
    other_errors = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    register_access();
    period_update();
    bypass_path();
    filter_response();
    saturation_limits();
    zero_frequency();

    $display("errors: word %0d, wave %0d, flag %0d, other %0d", word_errors, wave_errors,
             flag_errors, other_errors);
    if (word_errors == 0 && wave_errors == 0 && flag_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/iir_pkg.sv
hw/iir_apb_regs.sv
hw/long_divider.sv
hw/sample_enable.sv
hw/biquad_core.sv
hw/iir_biquad_system.sv
sim/iir_tb.sv

// File: Bender.yml
package:
  name: iir_biquad_system

sources:
  - hw/iir_pkg.sv
  - hw/iir_apb_regs.sv
  - hw/long_divider.sv
  - hw/sample_enable.sv
  - hw/biquad_core.sv
  - hw/iir_biquad_system.sv
  - target: simulation
    files:
      - sim/iir_tb.sv
